// ==== cache_pkg.sv ====
////////////////////
// Shared types and sizes for the data cache subsystem
// Address and data words, memory bus command and tag,
// address field split and its two-view union
////////////////////

`default_nettype none

package cache_pkg;

    // Sizes
    localparam int ADDR_BITS      = 16;
    localparam int WORD_BYTES     = 8;
    localparam int OFFSET_BITS    = $clog2(WORD_BYTES);
    localparam int CACHE_SETS_MAX = 16;
    localparam int INDEX_BITS_MAX = $clog2(CACHE_SETS_MAX);
    localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS_MAX - OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [63:0]          word_t;

    // Zero tag means no transaction
    typedef logic [3:0] mem_tag_t;

    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_e;

    // Sized for the largest cache, smaller caches fold index bits into the tag
    typedef struct packed {
        logic [TAG_BITS-1:0]       tag;
        logic [INDEX_BITS_MAX-1:0] index;
        logic [OFFSET_BITS-1:0]    offset;
    } addr_fields_t;

    typedef union packed {
        addr_t        raw;
        addr_fields_t fields;
    } addr_u;

endpackage

`default_nettype wire

// ==== dcache.sv ====
////////////////////
// Two-way set-associative write-back data cache
// Per-set LRU, write allocate without fetch,
// miss FSM with dirty victim writeback
////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache
    import cache_pkg::*;
#(
    parameter int CACHE_SETS = 16
) (
    input  logic     clock,
    input  logic     reset,

    // Processor side
    input  logic     read_en,
    input  logic     write_en,
    input  addr_u    proc_addr,
    input  word_t    proc_data,
    output word_t    load_data,
    output logic     load_valid,
    output logic     store_done,

    // Memory side
    output bus_cmd_e mem_command,
    output addr_u    mem_addr,
    output word_t    mem_wdata,
    input  mem_tag_t mem_response,
    input  mem_tag_t mem_rtag,
    input  word_t    mem_rdata
);

    localparam int SET_BITS  = $clog2(CACHE_SETS);
    localparam int LINE_BITS = TAG_BITS + INDEX_BITS_MAX;
    localparam int LTAG_BITS = LINE_BITS - SET_BITS;

    // Miss FSM states
    localparam logic [1:0] ST_IDLE        = 2'd0;
    localparam logic [1:0] ST_WRITEBACK   = 2'd1;
    localparam logic [1:0] ST_LOAD_ISSUED = 2'd2;
    localparam logic [1:0] ST_FILL_WAIT   = 2'd3;

    if (CACHE_SETS < 2 || CACHE_SETS > CACHE_SETS_MAX) begin : g_bad_sets
        $error("dcache: CACHE_SETS must be between 2 and %0d", CACHE_SETS_MAX);
    end

    // Address decode
    logic [LINE_BITS-1:0] line_addr;
    logic [SET_BITS-1:0]  set_idx;
    logic [LTAG_BITS-1:0] line_tag;

    // Arrays with one entry per way and set
    word_t                data_q  [2][CACHE_SETS];
    logic [LTAG_BITS-1:0] tag_q   [2][CACHE_SETS];
    logic [1:0]           valid_q [CACHE_SETS];
    logic [1:0]           dirty_q [CACHE_SETS];
    logic [CACHE_SETS-1:0] lru_q;

    // Lookup and control
    logic [1:0] way_hit;
    logic       hit;
    logic       hit_way;
    logic       victim_way;
    logic       victim_dirty;
    logic       touch_way;
    logic       miss;
    logic       accepted;
    logic       fill;
    logic       store_write;
    logic [1:0] state_q;
    logic [1:0] state_d;
    logic [1:0] phase;
    mem_tag_t   pend_tag_q;

    // Index masked to CACHE_SETS and upper index bits folded into the tag
    assign line_addr = {proc_addr.fields.tag, proc_addr.fields.index};
    assign set_idx   = line_addr[SET_BITS-1:0];
    assign line_tag  = line_addr[LINE_BITS-1:SET_BITS];

    ////////////////////
    // Hit lookup
    ////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[set_idx][w] && (tag_q[w][set_idx] == line_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = ~way_hit[0];

    // Invalid way before the LRU way
    assign victim_way   = !valid_q[set_idx][0] ? 1'b0 :
                          !valid_q[set_idx][1] ? 1'b1 : lru_q[set_idx];
    assign victim_dirty = valid_q[set_idx][victim_way] && dirty_q[set_idx][victim_way];
    assign touch_way    = hit ? hit_way : victim_way;

    assign load_valid = read_en && hit;
    assign load_data  = hit ? data_q[hit_way][set_idx] : '0;

    assign miss        = (read_en || write_en) && !hit;
    assign store_write = write_en && (state_q == ST_IDLE) && (hit || !victim_dirty);
    assign store_done  = store_write;

    ////////////////////
    // Miss FSM
    ////////////////////

    assign accepted = (mem_response != '0);
    assign fill     = (state_q == ST_FILL_WAIT) && (mem_rtag != '0) && (mem_rtag == pend_tag_q);

    // Idle enters the miss sequence in the same cycle
    always_comb begin
        phase = state_q;
        if (state_q == ST_IDLE && miss) begin
            if (victim_dirty) begin
                phase = ST_WRITEBACK;
            end else if (read_en) begin
                phase = ST_LOAD_ISSUED;
            end
        end
    end

    always_comb begin
        case (phase)
            ST_WRITEBACK:   state_d = (accepted && read_en) ? ST_LOAD_ISSUED : ST_IDLE;
            ST_LOAD_ISSUED: state_d = accepted ? ST_FILL_WAIT : ST_LOAD_ISSUED;
            ST_FILL_WAIT:   state_d = fill ? ST_IDLE : ST_FILL_WAIT;
            default:        state_d = ST_IDLE;
        endcase
    end

    // Memory command with the victim line on writeback
    always_comb begin
        mem_command = bus_none;
        mem_wdata   = '0;
        mem_addr.raw = {line_tag, set_idx, {OFFSET_BITS{1'b0}}};
        if (phase == ST_WRITEBACK) begin
            mem_command  = bus_store;
            mem_wdata    = data_q[victim_way][set_idx];
            mem_addr.raw = {tag_q[victim_way][set_idx], set_idx, {OFFSET_BITS{1'b0}}};
        end else if (phase == ST_LOAD_ISSUED) begin
            mem_command = bus_load;
        end
    end

    ////////////////////
    // State update
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q    <= ST_IDLE;
            pend_tag_q <= '0;
            lru_q      <= '0;
            for (int s = 0; s < CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            state_q <= state_d;
            if (phase == ST_LOAD_ISSUED && accepted) begin
                pend_tag_q <= mem_response;
            end
            // Victim is clean once memory has it
            if (phase == ST_WRITEBACK && accepted) begin
                dirty_q[set_idx][victim_way] <= 1'b0;
            end
            if (store_write || fill) begin
                valid_q[set_idx][touch_way] <= 1'b1;
                dirty_q[set_idx][touch_way] <= store_write;
            end
            if (store_write || fill || load_valid) begin
                lru_q[set_idx] <= ~touch_way;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (store_write || fill) begin
            data_q[touch_way][set_idx] <= fill ? mem_rdata : proc_data;
            tag_q[touch_way][set_idx]  <= line_tag;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_one_request: assert property (@(posedge clock) disable iff (reset)
        !(read_en && write_en))
        else $error("dcache: load and store requested together");

    a_fill_tag: assert property (@(posedge clock) disable iff (reset)
        (state_q == ST_FILL_WAIT && mem_rtag != '0) |-> (mem_rtag == pend_tag_q))
        else $error("dcache: response tag does not match the pending load");

    // No command out and no load response in flight while idle
    a_idle_quiet: assert property (@(posedge clock) disable iff (reset)
        (state_q == ST_IDLE && !miss) |-> (mem_command == bus_none && mem_rtag == '0))
        else $error("dcache: memory activity without a miss");

endmodule

`default_nettype wire

// ==== dmem.sv ====
////////////////////
// Tagged data memory
// Word array, tag counter and a fixed-latency
// load response pipeline
////////////////////

`timescale 1ns/1ps
`default_nettype none

module dmem
    import cache_pkg::*;
#(
    parameter int DMEM_LATENCY = 4,
    parameter int DMEM_WORDS   = 256
) (
    input  logic     clock,
    input  logic     reset,
    input  bus_cmd_e mem_command,
    input  addr_u    mem_addr,
    input  word_t    mem_wdata,
    output mem_tag_t mem_response,
    output mem_tag_t mem_rtag,
    output word_t    mem_rdata
);

    localparam int INDEX_BITS     = $clog2(DMEM_WORDS);
    localparam int WORD_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

    if (DMEM_LATENCY < 1) begin : g_bad_latency
        $error("dmem: DMEM_LATENCY must be at least 1");
    end

    logic [WORD_ADDR_BITS-1:0] word_addr;
    logic [INDEX_BITS-1:0]     word_idx;
    logic                      accept;

    word_t    mem_q       [DMEM_WORDS];
    mem_tag_t next_tag_q;
    mem_tag_t tag_pipe_q  [DMEM_LATENCY];
    word_t    data_pipe_q [DMEM_LATENCY];

    // Byte address to word index
    assign word_addr = mem_addr.raw[ADDR_BITS-1:OFFSET_BITS];
    assign word_idx  = word_addr[INDEX_BITS-1:0];

    // Every command is accepted with the current tag
    assign accept       = (mem_command != bus_none);
    assign mem_response = accept ? next_tag_q : '0;

    assign mem_rtag  = tag_pipe_q[DMEM_LATENCY-1];
    assign mem_rdata = data_pipe_q[DMEM_LATENCY-1];

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag_q <= 4'd1;
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
            for (int i = 0; i < DMEM_LATENCY; i++) begin
                tag_pipe_q[i] <= '0;
            end
        end else begin
            // Tags run 1 to 15, zero skipped
            if (accept) begin
                next_tag_q <= (next_tag_q == '1) ? 4'd1 : next_tag_q + 1'b1;
            end
            if (mem_command == bus_store) begin
                mem_q[word_idx] <= mem_wdata;
            end
            tag_pipe_q[0] <= (mem_command == bus_load) ? next_tag_q : '0;
            for (int i = 1; i < DMEM_LATENCY; i++) begin
                tag_pipe_q[i] <= tag_pipe_q[i-1];
            end
        end
    end

    // Read data follows its tag down the pipe
    always_ff @(posedge clock) begin
        data_pipe_q[0] <= mem_q[word_idx];
        for (int i = 1; i < DMEM_LATENCY; i++) begin
            data_pipe_q[i] <= data_pipe_q[i-1];
        end
    end

    a_word_range: assert property (@(posedge clock) disable iff (reset)
        (mem_command != bus_none) |-> (word_addr < DMEM_WORDS))
        else $error("dmem: word index %0d out of range", word_addr);

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
////////////////////
// Data cache subsystem top level
// Cache in front of the tagged data memory
////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import cache_pkg::*;
#(
    parameter int CACHE_SETS   = 16,
    parameter int DMEM_LATENCY = 4,
    parameter int DMEM_WORDS   = 256
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  read_en,
    input  logic  write_en,
    input  addr_u proc_addr,
    input  word_t proc_data,
    output word_t load_data,
    output logic  load_valid,
    output logic  store_done
);

    // Cache to memory bus
    bus_cmd_e mem_command;
    addr_u    mem_addr;
    word_t    mem_wdata;
    mem_tag_t mem_response;
    mem_tag_t mem_rtag;
    word_t    mem_rdata;

    dcache #(
        .CACHE_SETS   (CACHE_SETS)
    ) dcache_i (
        .clock        (clock),
        .reset        (reset),
        .read_en      (read_en),
        .write_en     (write_en),
        .proc_addr    (proc_addr),
        .proc_data    (proc_data),
        .load_data    (load_data),
        .load_valid   (load_valid),
        .store_done   (store_done),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_response (mem_response),
        .mem_rtag     (mem_rtag),
        .mem_rdata    (mem_rdata)
    );

    dmem #(
        .DMEM_LATENCY (DMEM_LATENCY),
        .DMEM_WORDS   (DMEM_WORDS)
    ) dmem_i (
        .clock        (clock),
        .reset        (reset),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_response (mem_response),
        .mem_rtag     (mem_rtag),
        .mem_rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_dcache_top.sv ====
////////////////////
// Testbench for the data cache subsystem
// Directed reset, hit, LRU and writeback cases,
// then random loads and stores against a flat memory model
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top
    import cache_pkg::*;
;

    localparam int CACHE_SETS   = 4;
    localparam int DMEM_LATENCY = 3;
    localparam int DMEM_WORDS   = 256;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int RANDOM_OPS   = 400;
    localparam int OP_LIMIT     = 2 * DMEM_LATENCY + 4;
    // Random loads may repeat once on top of directed cases and idle cycles
    localparam int TOTAL_OPS    = 2 * RANDOM_OPS + 40;
    localparam int WATCHDOG_NS  = (TOTAL_OPS * OP_LIMIT + RESET_CYCLES) * CLK_PERIOD;

    logic  clock;
    logic  reset;
    logic  read_en;
    logic  write_en;
    addr_u proc_addr;
    word_t proc_data;
    word_t load_data;
    logic  load_valid;
    logic  store_done;

    word_t       model [DMEM_WORDS];
    logic [31:0] rng;

    dcache_top #(
        .CACHE_SETS   (CACHE_SETS),
        .DMEM_LATENCY (DMEM_LATENCY),
        .DMEM_WORDS   (DMEM_WORDS)
    ) dut_i (
        .clock      (clock),
        .reset      (reset),
        .read_en    (read_en),
        .write_en   (write_en),
        .proc_addr  (proc_addr),
        .proc_data  (proc_data),
        .load_data  (load_data),
        .load_valid (load_valid),
        .store_done (store_done)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic stop_with_error();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic word_check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            stop_with_error();
        end
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            stop_with_error();
        end
    endtask

    task automatic cmd_check(input string name, input bus_cmd_e got, input bus_cmd_e exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            stop_with_error();
        end
    endtask

    task automatic tag_check(input string name, input mem_tag_t got, input mem_tag_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            stop_with_error();
        end
    endtask

    // Present a load at the falling edge and hold it until load_valid
    task automatic load_word(input addr_t addr, output logic first_hit);
        int cycles;
        @(negedge clock);
        read_en       = 1'b1;
        write_en      = 1'b0;
        proc_addr.raw = addr;
        cycles        = 0;
        #(CLK_PERIOD / 2 - 1);
        first_hit = load_valid;
        while (!load_valid) begin
            cycles++;
            if (cycles >= OP_LIMIT) begin
                $display("Load from address %h did not complete within %0d cycles",
                         addr, OP_LIMIT);
                stop_with_error();
            end
            @(negedge clock);
            #(CLK_PERIOD / 2 - 1);
        end
        word_check("load_data", load_data, model[addr[10:3]]);
    endtask

    task automatic store_word(input addr_t addr, input word_t data);
        int cycles;
        @(negedge clock);
        read_en       = 1'b0;
        write_en      = 1'b1;
        proc_addr.raw = addr;
        proc_data     = data;
        cycles        = 0;
        #(CLK_PERIOD / 2 - 1);
        while (!store_done) begin
            cycles++;
            if (cycles >= OP_LIMIT) begin
                $display("Store to address %h did not complete within %0d cycles",
                         addr, OP_LIMIT);
                stop_with_error();
            end
            @(negedge clock);
            #(CLK_PERIOD / 2 - 1);
        end
        model[addr[10:3]] = data;
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Simulation did not finish within %0d ns", WATCHDOG_NS);
        stop_with_error();
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        logic [31:0] r;
        addr_t       a;
        word_t       d;
        logic        first_hit;
        clock         = 1'b0;
        reset         = 1'b1;
        read_en       = 1'b0;
        write_en      = 1'b0;
        proc_addr.raw = '0;
        proc_data     = '0;
        rng           = 32'hcdff;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Quiet after reset
        repeat (3) begin
            @(negedge clock);
            #(CLK_PERIOD / 2 - 1);
            flag_check("load_valid", load_valid, 1'b0);
            flag_check("store_done", store_done, 1'b0);
            cmd_check("mem_command", dut_i.mem_command, bus_none);
            tag_check("mem_response", dut_i.mem_response, '0);
            tag_check("mem_rtag", dut_i.mem_rtag, '0);
        end
        // First load sees the zeroed memory
        load_word(16'h0008, first_hit);

        // Repeated load hits with no wait
        load_word(16'h0008, first_hit);
        flag_check("load_valid", first_hit, 1'b1);

        // LRU in set 0 where C must replace B and not A
        load_word(16'h0000, first_hit);
        load_word(16'h0020, first_hit);
        load_word(16'h0000, first_hit);
        store_word(16'h0040, 64'h1111_2222_3333_4444);
        load_word(16'h0000, first_hit);
        flag_check("load_valid", first_hit, 1'b1);
        load_word(16'h0020, first_hit);
        flag_check("load_valid", first_hit, 1'b0);

        // Dirty victims in set 2 go back to memory
        store_word(16'h0030, 64'h0bad_cafe_1234_5678);
        store_word(16'h0010, 64'h5eed_f00d_9abc_def0);
        load_word(16'h0050, first_hit);
        load_word(16'h0070, first_hit);
        load_word(16'h0010, first_hit);
        load_word(16'h0030, first_hit);

        // Random mix over 16 words with four per set
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = next_random();
            a = addr_t'(int'(r[3:0]) * 56);
            if (r[8]) begin
                d = {next_random(), next_random()};
                store_word(a, d);
            end else begin
                load_word(a, first_hit);
                if (r[9]) begin
                    load_word(a, first_hit);
                    flag_check("load_valid", first_hit, 1'b1);
                end
            end
        end

        @(negedge clock);
        read_en  = 1'b0;
        write_en = 1'b0;
        repeat (2) @(posedge clock);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
cache_pkg.sv
dcache.sv
dmem.sv
dcache_top.sv
tb_dcache_top.sv

// ==== Makefile ====
# Verilator build and run for the data cache subsystem

SRCS := cache_pkg.sv dcache.sv dmem.sv dcache_top.sv tb_dcache_top.sv

obj_dir/Vtb_dcache_top: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache_top -f vlog.f

run: obj_dir/Vtb_dcache_top
	./obj_dir/Vtb_dcache_top

clean:
	rm -rf obj_dir

.PHONY: run clean
